//--- project.f
logic/neuroConfPkg.sv
logic/progWordIf.sv
logic/chunkDeserializer.sv
logic/hostWordParser.sv
logic/confRegFile.sv
logic/confMapper.sv
logic/confFrontEnd.sv
bench/confFrontEnd_checker.sv
bench/confFrontEnd_tb.sv

//--- Bender.yml
package:
  name: conf_front_end

sources:
  - logic/neuroConfPkg.sv
  - logic/progWordIf.sv
  - logic/chunkDeserializer.sv
  - logic/hostWordParser.sv
  - logic/confRegFile.sv
  - logic/confMapper.sv
  - logic/confFrontEnd.sv
  - target: simulation
    files:
      - bench/confFrontEnd_checker.sv
      - bench/confFrontEnd_tb.sv

//--- bench/confFrontEnd_tb.sv
`timescale 1ns/1ns

module confFrontEnd_tb;

  localparam int NumRegs      = 32;
  localparam int HostTimeout  = 200;
  localparam int DrainTimeout = 2000;
  localparam int MixedWords   = 400;
  localparam int TicksLsb     = neuroConfPkg::TagWidth;
  localparam int PeriodLsb    = TicksLsb + neuroConfPkg::PeriodWidth;
  localparam int GenLsb       = PeriodLsb + neuroConfPkg::PeriodWidth;

  logic                                 clk;
  logic                                 rstN;
  logic [neuroConfPkg::HostWidth-1:0]   hostData;
  logic                                 hostValid;
  logic                                 hostReady;
  logic [neuroConfPkg::BdWidth-1:0]     bdData;
  logic                                 bdValid;
  logic                                 bdReady;
  logic [neuroConfPkg::FiltsWidth-1:0]  sfFiltsUsed;
  logic [neuroConfPkg::StateWidth-1:0]  sfIncrement;
  logic [neuroConfPkg::StateWidth-1:0]  sfDecay;
  logic [neuroConfPkg::GensWidth-1:0]   sgGensUsed;
  logic [neuroConfPkg::GensEnWidth-1:0] sgGensEn;
  logic [neuroConfPkg::UnitWidth-1:0]   tmUnitLen;
  logic [neuroConfPkg::TimeWidth-1:0]   tmElapsedLo;
  logic [neuroConfPkg::TimeWidth-1:0]   tmElapsedHi;
  logic [neuroConfPkg::GensWidth-1:0]   pgmGenIdx;
  logic [neuroConfPkg::PeriodWidth-1:0] pgmPeriod;
  logic [neuroConfPkg::PeriodWidth-1:0] pgmTicks;
  logic [neuroConfPkg::TagWidth-1:0]    pgmTag;
  logic                                 pgmValid;
  logic                                 pgmReady;

  // reference state
  logic [neuroConfPkg::ConfWidth-1:0] modelRegs [NumRegs];
  logic [neuroConfPkg::ConfWidth-1:0] chunkQ [$];
  logic [neuroConfPkg::ProgWidth-1:0] progQ [$];
  logic [neuroConfPkg::BdWidth-1:0]   bdQ [$];
  logic [31:0]                        stimRng;
  logic [31:0]                        stallRng;
  int                                 valueErrors = 0;
  int                                 protocolErrors = 0;

  confFrontEnd #(.NumRegs(NumRegs)) u_dut (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference model

  function automatic logic [neuroConfPkg::ProgWidth-1:0] expectProg();
    logic [4*neuroConfPkg::ConfWidth-1:0] full;
    // first chunk is the low part
    full = {chunkQ[3], chunkQ[2], chunkQ[1], chunkQ[0]};
    return full[neuroConfPkg::ProgWidth-1:0];
  endfunction

  function automatic void applyWord(input logic [neuroConfPkg::HostWidth-1:0] w);
    neuroConfPkg::hostOp op;
    op = neuroConfPkg::hostOp'(w[23:22]);
    case (op)
      neuroConfPkg::opRegWrite: begin
        if (int'(w[20:16]) < NumRegs) begin
          modelRegs[w[20:16]] = w[15:0];
        end
      end
      neuroConfPkg::opChanWrite: begin
        chunkQ.push_back(w[15:0]);
        if (chunkQ.size() == 4) begin
          progQ.push_back(expectProg());
          chunkQ.delete();
        end
      end
      neuroConfPkg::opPassthrough: bdQ.push_back(w[21:0]);
      default: ;
    endcase
  endfunction

  function automatic logic [31:0] regPair(input int idx);
    return {modelRegs[idx+1], modelRegs[idx]};
  endfunction

  function automatic neuroConfPkg::spikeFilterConf expectFilter();
    neuroConfPkg::spikeFilterConf c;
    logic [31:0] p;
    c.filtsUsed = modelRegs[neuroConfPkg::FiltsUsedIdx][neuroConfPkg::FiltsWidth-1:0];
    p = regPair(neuroConfPkg::IncrementIdx);
    c.incrementConst = p[neuroConfPkg::StateWidth-1:0];
    p = regPair(neuroConfPkg::DecayIdx);
    c.decayConst = p[neuroConfPkg::StateWidth-1:0];
    return c;
  endfunction

  function automatic neuroConfPkg::spikeGenConf expectGen();
    neuroConfPkg::spikeGenConf c;
    c.gensUsed = modelRegs[neuroConfPkg::GensUsedIdx][neuroConfPkg::GensWidth-1:0];
    for (int i = 0; i < 16; i++) begin
      c.gensEn[i*16 +: 16] = modelRegs[neuroConfPkg::GensEnIdx + i];
    end
    return c;
  endfunction

  function automatic neuroConfPkg::timeMgrConf expectTime();
    neuroConfPkg::timeMgrConf c;
    logic [31:0] p;
    c.unitLen = modelRegs[neuroConfPkg::UnitLenIdx];
    p = regPair(neuroConfPkg::ElapsedLoIdx);
    c.elapsedLo = p[neuroConfPkg::TimeWidth-1:0];
    p = regPair(neuroConfPkg::ElapsedHiIdx);
    c.elapsedHi = p[neuroConfPkg::TimeWidth-1:0];
    return c;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic reportValue(input string name, input logic [255:0] expVal,
                             input logic [255:0] actVal);
    valueErrors++;
    $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, expVal, actVal);
  endtask

  task automatic checkFilter(input neuroConfPkg::spikeFilterConf e,
                             input neuroConfPkg::spikeFilterConf a);
    if (e.filtsUsed !== a.filtsUsed)
      reportValue("sfFiltsUsed", 256'(e.filtsUsed), 256'(a.filtsUsed));
    if (e.incrementConst !== a.incrementConst)
      reportValue("sfIncrement", 256'(e.incrementConst), 256'(a.incrementConst));
    if (e.decayConst !== a.decayConst)
      reportValue("sfDecay", 256'(e.decayConst), 256'(a.decayConst));
  endtask

  task automatic checkGen(input neuroConfPkg::spikeGenConf e,
                          input neuroConfPkg::spikeGenConf a);
    if (e.gensUsed !== a.gensUsed)
      reportValue("sgGensUsed", 256'(e.gensUsed), 256'(a.gensUsed));
    if (e.gensEn !== a.gensEn)
      reportValue("sgGensEn", e.gensEn, a.gensEn);
  endtask

  task automatic checkTime(input neuroConfPkg::timeMgrConf e,
                           input neuroConfPkg::timeMgrConf a);
    if (e.unitLen !== a.unitLen)
      reportValue("tmUnitLen", 256'(e.unitLen), 256'(a.unitLen));
    if (e.elapsedLo !== a.elapsedLo)
      reportValue("tmElapsedLo", 256'(e.elapsedLo), 256'(a.elapsedLo));
    if (e.elapsedHi !== a.elapsedHi)
      reportValue("tmElapsedHi", 256'(e.elapsedHi), 256'(a.elapsedHi));
  endtask

  task automatic checkProg(input logic [neuroConfPkg::ProgWidth-1:0] e,
                           input logic [neuroConfPkg::ProgWidth-1:0] a);
    if (e[GenLsb +: neuroConfPkg::GensWidth] !== a[GenLsb +: neuroConfPkg::GensWidth])
      reportValue("pgmGenIdx", 256'(e[GenLsb +: 8]), 256'(a[GenLsb +: 8]));
    if (e[PeriodLsb +: 16] !== a[PeriodLsb +: 16])
      reportValue("pgmPeriod", 256'(e[PeriodLsb +: 16]), 256'(a[PeriodLsb +: 16]));
    if (e[TicksLsb +: 16] !== a[TicksLsb +: 16])
      reportValue("pgmTicks", 256'(e[TicksLsb +: 16]), 256'(a[TicksLsb +: 16]));
    if (e[0 +: neuroConfPkg::TagWidth] !== a[0 +: neuroConfPkg::TagWidth])
      reportValue("pgmTag", 256'(e[0 +: 11]), 256'(a[0 +: 11]));
  endtask

  task automatic checkBd(input logic [neuroConfPkg::BdWidth-1:0] e,
                         input logic [neuroConfPkg::BdWidth-1:0] a);
    if (e !== a)
      reportValue("bdData", 256'(e), 256'(a));
  endtask

  task automatic checkConfig();
    neuroConfPkg::spikeFilterConf sfAct;
    neuroConfPkg::spikeGenConf    sgAct;
    neuroConfPkg::timeMgrConf     tmAct;
    sfAct = '{filtsUsed: sfFiltsUsed, incrementConst: sfIncrement, decayConst: sfDecay};
    sgAct = '{gensUsed: sgGensUsed, gensEn: sgGensEn};
    tmAct = '{unitLen: tmUnitLen, elapsedLo: tmElapsedLo, elapsedHi: tmElapsedHi};
    checkFilter(expectFilter(), sfAct);
    checkGen(expectGen(), sgAct);
    checkTime(expectTime(), tmAct);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  // called 1 ns after a rising edge
  task automatic sendWord(input logic [neuroConfPkg::HostWidth-1:0] w);
    int waitCycles;
    waitCycles = 0;
    hostData  = w;
    hostValid = 1'b1;
    @(posedge clk);
    while (!hostReady && waitCycles < HostTimeout) begin
      waitCycles++;
      @(posedge clk);
    end
    if (hostReady) begin
      applyWord(w);
    end else begin
      protocolErrors++;
      $display("host word %h was never accepted", w);
    end
    #1;
    hostValid = 1'b0;
  endtask

  function automatic logic [neuroConfPkg::HostWidth-1:0] randomWord();
    logic [31:0] r;
    logic [31:0] d;
    stimRng = xorshift(stimRng);
    r = stimRng;
    stimRng = xorshift(stimRng);
    d = stimRng;
    case (r[2:0])
      3'd0, 3'd1, 3'd2:
        return {2'd0, 1'b0, 5'(int'(r[12:8]) % neuroConfPkg::UsedRegs), d[15:0]};
      3'd3, 3'd4: return {2'd1, d[21:0]};
      3'd5, 3'd6: return {2'd2, d[21:0]};
      default:    return {2'd3, d[21:0]};
    endcase
  endfunction

  // register update lands two edges after the last accept
  task automatic settle();
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic drainOutputs();
    int waitCycles;
    waitCycles = 0;
    while ((bdQ.size() != 0 || progQ.size() != 0) && waitCycles < DrainTimeout) begin
      @(posedge clk);
      waitCycles++;
    end
    if (bdQ.size() != 0 || progQ.size() != 0) begin
      protocolErrors++;
      $display("%0d downstream and %0d program words never arrived",
               bdQ.size(), progQ.size());
    end
  endtask

  // random stalls on both output channels
  always @(posedge clk) begin
    #1;
    stallRng = xorshift(stallRng);
    bdReady  = stallRng[1:0] != 2'b00;
    pgmReady = stallRng[4:3] != 2'b00;
  end

  // pops expected words on every output transfer
  always @(posedge clk) begin
    if (rstN && bdValid && bdReady) begin
      if (bdQ.size() == 0) begin
        protocolErrors++;
        $display("unexpected downstream word %h at %0t ns", bdData, $time);
      end else begin
        checkBd(bdQ.pop_front(), bdData);
      end
    end
    if (rstN && pgmValid && pgmReady) begin
      if (progQ.size() == 0) begin
        protocolErrors++;
        $display("unexpected program word at %0t ns", $time);
      end else begin
        checkProg(progQ.pop_front(), {pgmGenIdx, pgmPeriod, pgmTicks, pgmTag});
      end
    end
  end

  initial begin
    clk       = 1'b0;
    rstN      = 1'b0;
    hostData  = '0;
    hostValid = 1'b0;
    bdReady   = 1'b0;
    pgmReady  = 1'b0;
    stimRng   = 32'h2c6f45ed;
    stallRng  = xorshift(32'h2c6f45ed);
    for (int i = 0; i < NumRegs; i++) begin
      modelRegs[i] = '0;
    end
    modelRegs[neuroConfPkg::UnitLenIdx]   = 16'd5000;
    modelRegs[neuroConfPkg::IncrementIdx] = 16'd1;

    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;
    @(posedge clk);
    #1;
    if (!hostReady) begin
      protocolErrors++;
      $display("hostReady is low after reset");
    end
    checkConfig();

    // every used register once, then mixed traffic
    for (int a = 0; a < neuroConfPkg::UsedRegs; a++) begin
      stimRng = xorshift(stimRng);
      sendWord({2'd0, 1'b0, 5'(a), stimRng[15:0]});
    end
    for (int n = 0; n < MixedWords; n++) begin
      sendWord(randomWord());
    end
    // complete a partial chunk group, at most one group long
    for (int n = 0; n < neuroConfPkg::ProgChunks && chunkQ.size() != 0; n++) begin
      stimRng = xorshift(stimRng);
      sendWord({2'd1, stimRng[21:0]});
    end
    settle();
    checkConfig();

    // reserved registers and nops
    for (int a = neuroConfPkg::UsedRegs; a < NumRegs; a++) begin
      stimRng = xorshift(stimRng);
      sendWord({2'd0, 1'b0, 5'(a), stimRng[15:0]});
    end
    for (int n = 0; n < 8; n++) begin
      stimRng = xorshift(stimRng);
      sendWord({2'd3, stimRng[21:0]});
    end
    settle();
    checkConfig();
    drainOutputs();
    repeat (4) @(posedge clk);

    $display("value errors: %0d, protocol errors: %0d, assertion failures: %0d",
             valueErrors, protocolErrors, u_dut.uChecker.assertFails);
    if (valueErrors + protocolErrors + u_dut.uChecker.assertFails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- bench/confFrontEnd_checker.sv
`timescale 1ns/1ns

module confFrontEnd_checker (
  input logic                                 clk,
  input logic                                 rstN,
  input logic                                 regWe,
  input logic [neuroConfPkg::BdWidth-1:0]     bdData,
  input logic                                 bdValid,
  input logic                                 bdReady,
  input logic [neuroConfPkg::GensWidth-1:0]   pgmGenIdx,
  input logic [neuroConfPkg::PeriodWidth-1:0] pgmPeriod,
  input logic [neuroConfPkg::PeriodWidth-1:0] pgmTicks,
  input logic [neuroConfPkg::TagWidth-1:0]    pgmTag,
  input logic                                 pgmValid,
  input logic                                 pgmReady
);

  int assertFails = 0;
  logic [neuroConfPkg::ProgWidth-1:0] pgmWord;

  assign pgmWord = {pgmGenIdx, pgmPeriod, pgmTicks, pgmTag};

  ////////////////////////////////////////////////////////////////////////////
  // stalled words hold until taken

  bdHold: assert property (@(posedge clk) disable iff (!rstN)
    bdValid && !bdReady |=> bdValid && $stable(bdData))
    else begin
      assertFails++;
      $error("downstream word changed or dropped while stalled");
    end

  pgmHold: assert property (@(posedge clk) disable iff (!rstN)
    pgmValid && !pgmReady |=> pgmValid && $stable(pgmWord))
    else begin
      assertFails++;
      $error("program word changed or dropped while stalled");
    end

  // outputs stay quiet in reset
  quietInReset: assert property (@(posedge clk)
    !rstN |-> !bdValid && !pgmValid && !regWe)
    else begin
      assertFails++;
      $error("valid or write strobe high during reset");
    end

endmodule

bind confFrontEnd confFrontEnd_checker uChecker (.*);

//--- logic/confFrontEnd.sv
`timescale 1ns/1ns

module confFrontEnd #(
  parameter int NumRegs = 32
) (
  input  logic                                    clk,
  input  logic                                    rstN,
  input  logic [neuroConfPkg::HostWidth-1:0]      hostData,
  input  logic                                    hostValid,
  output logic                                    hostReady,
  output logic [neuroConfPkg::BdWidth-1:0]        bdData,
  output logic                                    bdValid,
  input  logic                                    bdReady,
  output logic [neuroConfPkg::FiltsWidth-1:0]     sfFiltsUsed,
  output logic [neuroConfPkg::StateWidth-1:0]     sfIncrement,
  output logic [neuroConfPkg::StateWidth-1:0]     sfDecay,
  output logic [neuroConfPkg::GensWidth-1:0]      sgGensUsed,
  output logic [neuroConfPkg::GensEnWidth-1:0]    sgGensEn,
  output logic [neuroConfPkg::UnitWidth-1:0]      tmUnitLen,
  output logic [neuroConfPkg::TimeWidth-1:0]      tmElapsedLo,
  output logic [neuroConfPkg::TimeWidth-1:0]      tmElapsedHi,
  output logic [neuroConfPkg::GensWidth-1:0]      pgmGenIdx,
  output logic [neuroConfPkg::PeriodWidth-1:0]    pgmPeriod,
  output logic [neuroConfPkg::PeriodWidth-1:0]    pgmTicks,
  output logic [neuroConfPkg::TagWidth-1:0]       pgmTag,
  output logic                                    pgmValid,
  input  logic                                    pgmReady
);

  logic                                            regWe;
  logic [neuroConfPkg::AddrWidth-1:0]              regAddr;
  logic [neuroConfPkg::ConfWidth-1:0]              regData;
  logic [neuroConfPkg::ConfWidth-1:0]              chanData;
  logic                                            chanValid;
  logic                                            chanReady;
  logic [NumRegs-1:0][neuroConfPkg::ConfWidth-1:0] regs;
  logic [NumRegs-1:0][neuroConfPkg::ConfWidth-1:0] resetVals;
  neuroConfPkg::spikeFilterConf                    sfConf;
  neuroConfPkg::spikeGenConf                       sgConf;
  neuroConfPkg::timeMgrConf                        tmConf;

  progWordIf prog ();

  hostWordParser #(.NumRegs(NumRegs)) uParser (.*);

  confRegFile #(.NumRegs(NumRegs)) uRegFile (.*);

  confMapper #(.NumRegs(NumRegs)) uMapper (.*);

  ////////////////////////////////////////////////////////////////////////////
  // flatten config structs and program word

  assign sfFiltsUsed = sfConf.filtsUsed;
  assign sfIncrement = sfConf.incrementConst;
  assign sfDecay     = sfConf.decayConst;
  assign sgGensUsed  = sgConf.gensUsed;
  assign sgGensEn    = sgConf.gensEn;
  assign tmUnitLen   = tmConf.unitLen;
  assign tmElapsedLo = tmConf.elapsedLo;
  assign tmElapsedHi = tmConf.elapsedHi;

  assign pgmGenIdx  = prog.genIdx;
  assign pgmPeriod  = prog.period;
  assign pgmTicks   = prog.ticks;
  assign pgmTag     = prog.tag;
  assign pgmValid   = prog.valid;
  assign prog.ready = pgmReady;

endmodule

//--- logic/confMapper.sv
`timescale 1ns/1ns

module confMapper #(
  parameter int NumRegs = 32
) (
  input  logic                                             clk,
  input  logic                                             rstN,
  input  logic [NumRegs-1:0][neuroConfPkg::ConfWidth-1:0]  regs,
  input  logic [neuroConfPkg::ConfWidth-1:0]               chanData,
  input  logic                                             chanValid,
  output logic                                             chanReady,
  output logic [NumRegs-1:0][neuroConfPkg::ConfWidth-1:0]  resetVals,
  output neuroConfPkg::spikeFilterConf                     sfConf,
  output neuroConfPkg::spikeGenConf                        sgConf,
  output neuroConfPkg::timeMgrConf                         tmConf,
  progWordIf.source                                        prog
);

  localparam int CW = neuroConfPkg::ConfWidth;

  logic [NumRegs*CW-1:0]                  regBits;
  logic [NumRegs*CW-1:0]                  resetBits;
  logic [neuroConfPkg::ProgBusWidth-1:0]  progBits;

  ////////////////////////////////////////////////////////////////////////////
  // register slicing, lowest register holds the low bits

  assign regBits = regs;

  assign sfConf.filtsUsed      = regBits[neuroConfPkg::FiltsUsedIdx*CW +: neuroConfPkg::FiltsWidth];
  assign sfConf.incrementConst = regBits[neuroConfPkg::IncrementIdx*CW +: neuroConfPkg::StateWidth];
  assign sfConf.decayConst     = regBits[neuroConfPkg::DecayIdx*CW +: neuroConfPkg::StateWidth];

  assign sgConf.gensUsed = regBits[neuroConfPkg::GensUsedIdx*CW +: neuroConfPkg::GensWidth];
  assign sgConf.gensEn   = regBits[neuroConfPkg::GensEnIdx*CW +: neuroConfPkg::GensEnWidth];

  assign tmConf.unitLen   = regBits[neuroConfPkg::UnitLenIdx*CW +: neuroConfPkg::UnitWidth];
  assign tmConf.elapsedLo = regBits[neuroConfPkg::ElapsedLoIdx*CW +: neuroConfPkg::TimeWidth];
  assign tmConf.elapsedHi = regBits[neuroConfPkg::ElapsedHiIdx*CW +: neuroConfPkg::TimeWidth];

  ////////////////////////////////////////////////////////////////////////////
  // reset values, reserved registers stay zero

  always_comb begin
    resetBits = '0;
    // filters off, decay mode
    resetBits[neuroConfPkg::FiltsUsedIdx*CW +: neuroConfPkg::FiltsWidth] = '0;
    resetBits[neuroConfPkg::IncrementIdx*CW +: neuroConfPkg::StateWidth] =
      neuroConfPkg::IncrementReset;
    resetBits[neuroConfPkg::DecayIdx*CW +: neuroConfPkg::StateWidth] = '0;
    // all generators disabled
    resetBits[neuroConfPkg::GensUsedIdx*CW +: neuroConfPkg::GensWidth]  = '0;
    resetBits[neuroConfPkg::GensEnIdx*CW +: neuroConfPkg::GensEnWidth]  = '0;
    resetBits[neuroConfPkg::UnitLenIdx*CW +: neuroConfPkg::UnitWidth]   =
      neuroConfPkg::UnitLenReset;
    resetBits[neuroConfPkg::ElapsedLoIdx*CW +: neuroConfPkg::TimeWidth] = '0;
    resetBits[neuroConfPkg::ElapsedHiIdx*CW +: neuroConfPkg::TimeWidth] = '0;
  end

  assign resetVals = resetBits;

  ////////////////////////////////////////////////////////////////////////////
  // program channel

  chunkDeserializer #(
    .InWidth  (CW),
    .OutWidth (neuroConfPkg::ProgBusWidth)
  ) uProgDes (
    .clk      (clk),
    .rstN     (rstN),
    .inData   (chanData),
    .inValid  (chanValid),
    .inReady  (chanReady),
    .outData  (progBits),
    .outValid (prog.valid),
    .outReady (prog.ready)
  );

  // bits above the program word are dropped
  assign {prog.genIdx, prog.period, prog.ticks, prog.tag} =
    progBits[neuroConfPkg::ProgWidth-1:0];

endmodule

//--- logic/confRegFile.sv
`timescale 1ns/1ns

module confRegFile #(
  parameter int NumRegs = 32
) (
  input  logic                                             clk,
  input  logic                                             rstN,
  input  logic                                             regWe,
  input  logic [neuroConfPkg::AddrWidth-1:0]               regAddr,
  input  logic [neuroConfPkg::ConfWidth-1:0]               regData,
  input  logic [NumRegs-1:0][neuroConfPkg::ConfWidth-1:0]  resetVals,
  output logic [NumRegs-1:0][neuroConfPkg::ConfWidth-1:0]  regs
);

  // per-register write strobes
  logic [NumRegs-1:0] regSel;

  always_comb begin
    regSel = '0;
    for (int i = 0; i < NumRegs; i++) begin
      regSel[i] = regWe && (int'(regAddr) == i);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // register array, reset loads the mapper defaults

  for (genvar i = 0; i < NumRegs; i++) begin : gReg
    always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
        regs[i] <= resetVals[i];
      end else if (regSel[i]) begin
        regs[i] <= regData;
      end
    end
  end

endmodule

//--- logic/hostWordParser.sv
`timescale 1ns/1ns

module hostWordParser #(
  parameter int NumRegs = 32
) (
  input  logic                                 clk,
  input  logic                                 rstN,
  input  logic [neuroConfPkg::HostWidth-1:0]   hostData,
  input  logic                                 hostValid,
  output logic                                 hostReady,
  output logic                                 regWe,
  output logic [neuroConfPkg::AddrWidth-1:0]   regAddr,
  output logic [neuroConfPkg::ConfWidth-1:0]   regData,
  output logic [neuroConfPkg::ConfWidth-1:0]   chanData,
  output logic                                 chanValid,
  input  logic                                 chanReady,
  output logic [neuroConfPkg::BdWidth-1:0]     bdData,
  output logic                                 bdValid,
  input  logic                                 bdReady
);

  logic [neuroConfPkg::HostWidth-1:0] slotWord;
  logic                               slotValid;
  logic                               slotTaken;
  logic                               addrOk;
  neuroConfPkg::hostOp                slotOp;

  assign slotOp  = neuroConfPkg::hostOp'(slotWord[neuroConfPkg::OpLsb +: 2]);
  assign regAddr = slotWord[neuroConfPkg::AddrLsb +: neuroConfPkg::AddrWidth];
  assign addrOk  = int'(regAddr) < NumRegs;

  ////////////////////////////////////////////////////////////////////////////
  // route the slot word to its target

  assign regData  = slotWord[neuroConfPkg::ConfWidth-1:0];
  assign chanData = slotWord[neuroConfPkg::ConfWidth-1:0];
  assign bdData   = slotWord[neuroConfPkg::BdWidth-1:0];

  assign regWe     = slotValid && (slotOp == neuroConfPkg::opRegWrite) && addrOk;
  assign chanValid = slotValid && (slotOp == neuroConfPkg::opChanWrite);
  assign bdValid   = slotValid && (slotOp == neuroConfPkg::opPassthrough);

  // register writes and nops always leave after one cycle
  always_comb begin
    slotTaken = 1'b0;
    if (slotValid) begin
      unique case (slotOp)
        neuroConfPkg::opChanWrite:   slotTaken = chanReady;
        neuroConfPkg::opPassthrough: slotTaken = bdReady;
        default:                     slotTaken = 1'b1;
      endcase
    end
  end

  assign hostReady = !slotValid || slotTaken;

  ////////////////////////////////////////////////////////////////////////////
  // one-word slot

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      slotValid <= 1'b0;
    end else if (hostValid && hostReady) begin
      slotValid <= 1'b1;
    end else if (slotTaken) begin
      slotValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (hostValid && hostReady) begin
      slotWord <= hostData;
    end
  end

endmodule

//--- logic/chunkDeserializer.sv
`timescale 1ns/1ns

module chunkDeserializer #(
  parameter int InWidth  = 16,
  parameter int OutWidth = 64
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic [InWidth-1:0]  inData,
  input  logic                inValid,
  output logic                inReady,
  output logic [OutWidth-1:0] outData,
  output logic                outValid,
  input  logic                outReady
);

  localparam int Chunks   = OutWidth / InWidth;
  localparam int CntWidth = (Chunks > 1) ? $clog2(Chunks) : 1;

  logic [CntWidth-1:0] chunkCnt;
  logic [OutWidth-1:0] shiftReg;
  logic                inFire;
  logic                lastChunk;

  // no new chunks while a full word waits
  assign inReady   = !outValid;
  assign inFire    = inValid && inReady;
  assign lastChunk = (int'(chunkCnt) == Chunks - 1);
  assign outData   = shiftReg;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      chunkCnt <= '0;
      outValid <= 1'b0;
    end else begin
      if (outValid && outReady) begin
        outValid <= 1'b0;
      end
      if (inFire) begin
        if (lastChunk) begin
          chunkCnt <= '0;
          outValid <= 1'b1;
        end else begin
          chunkCnt <= chunkCnt + 1'b1;
        end
      end
    end
  end

  // new chunk enters at the top, first chunk ends up lowest
  always_ff @(posedge clk) begin
    if (inFire) begin
      shiftReg <= {inData, shiftReg[OutWidth-1:InWidth]};
    end
  end

endmodule

//--- logic/progWordIf.sv
`timescale 1ns/1ns

interface progWordIf;

  // one generator program entry
  logic [neuroConfPkg::GensWidth-1:0]   genIdx;
  logic [neuroConfPkg::PeriodWidth-1:0] period;
  logic [neuroConfPkg::PeriodWidth-1:0] ticks;
  logic [neuroConfPkg::TagWidth-1:0]    tag;
  logic                                 valid;
  logic                                 ready;

  modport source (
    output genIdx, period, ticks, tag, valid,
    input  ready
  );

  modport sink (
    input  genIdx, period, ticks, tag, valid,
    output ready
  );

endinterface

//--- logic/neuroConfPkg.sv
package neuroConfPkg;

  ////////////////////////////////////////////////////////////////////////////
  // host word format

  typedef enum logic [1:0] {
    opRegWrite    = 2'd0,
    opChanWrite   = 2'd1,
    opPassthrough = 2'd2,
    opNop         = 2'd3
  } hostOp;

  localparam int HostWidth = 24;
  localparam int ConfWidth = 16;
  localparam int BdWidth   = 22;
  localparam int OpLsb     = 22;
  localparam int AddrLsb   = 16;
  localparam int AddrWidth = 5;

  ////////////////////////////////////////////////////////////////////////////
  // config fields and register layout

  localparam int FiltsWidth  = 10;
  localparam int StateWidth  = 27;
  localparam int GensWidth   = 8;
  localparam int GensEnWidth = 256;
  localparam int UnitWidth   = 16;
  localparam int TimeWidth   = 20;
  localparam int PeriodWidth = 16;
  localparam int TagWidth    = 11;

  // whole registers per field, rounded up
  localparam int FiltsRegs  = (FiltsWidth + ConfWidth - 1) / ConfWidth;
  localparam int StateRegs  = (StateWidth + ConfWidth - 1) / ConfWidth;
  localparam int GensRegs   = (GensWidth + ConfWidth - 1) / ConfWidth;
  localparam int GensEnRegs = (GensEnWidth + ConfWidth - 1) / ConfWidth;
  localparam int UnitRegs   = (UnitWidth + ConfWidth - 1) / ConfWidth;
  localparam int TimeRegs   = (TimeWidth + ConfWidth - 1) / ConfWidth;

  localparam int FiltsUsedIdx = 0;
  localparam int IncrementIdx = FiltsUsedIdx + FiltsRegs;
  localparam int DecayIdx     = IncrementIdx + StateRegs;
  localparam int GensUsedIdx  = DecayIdx + StateRegs;
  localparam int GensEnIdx    = GensUsedIdx + GensRegs;
  localparam int UnitLenIdx   = GensEnIdx + GensEnRegs;
  localparam int ElapsedLoIdx = UnitLenIdx + UnitRegs;
  localparam int ElapsedHiIdx = ElapsedLoIdx + TimeRegs;
  localparam int UsedRegs     = ElapsedHiIdx + TimeRegs;

  // 5000 cycles per time unit at 200 MHz gives 25 us
  localparam logic [UnitWidth-1:0]  UnitLenReset   = 16'd5000;
  localparam logic [StateWidth-1:0] IncrementReset = 27'd1;

  typedef struct packed {
    logic [FiltsWidth-1:0] filtsUsed;
    logic [StateWidth-1:0] incrementConst;
    logic [StateWidth-1:0] decayConst;
  } spikeFilterConf;

  typedef struct packed {
    logic [GensWidth-1:0]   gensUsed;
    logic [GensEnWidth-1:0] gensEn;
  } spikeGenConf;

  typedef struct packed {
    logic [UnitWidth-1:0] unitLen;
    logic [TimeWidth-1:0] elapsedLo;
    logic [TimeWidth-1:0] elapsedHi;
  } timeMgrConf;

  ////////////////////////////////////////////////////////////////////////////
  // generator program word

  localparam int ProgWidth    = GensWidth + 2 * PeriodWidth + TagWidth;
  localparam int ProgChunks   = 4;
  localparam int ProgBusWidth = ConfWidth * ProgChunks;

endpackage
